/* Bender.yml */
package:
  name: floor_logic

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/floor_pkg.sv
      - source/request_latch.sv
      - source/floor_scheduler.sv
      - source/dispatch_control.sv
      - source/floor_logic_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/floor_logic_checker.sv
      - tests/floor_logic_tb.sv

/* sim.f */
+incdir+source
source/floor_pkg.sv
source/request_latch.sv
source/floor_scheduler.sv
source/dispatch_control.sv
source/floor_logic_top.sv
tests/floor_logic_checker.sv
tests/floor_logic_tb.sv

/* source/dispatch_control.sv */
// Stage 3 of the floor-request pipeline.
// Registers the activation, direction and floor selector for the motion
// machine, and grants the door buttons only while stopped with power on.

`timescale 1ns/1ps

module dispatch_control (
    input  logic                 clock,
    input  logic                 reset_n,
    input  floor_pkg::target_t   target,
    output floor_pkg::dispatch_t dispatch
);

    logic cab_ready;
    logic activate_next;
    logic going_up;

    // Motion can only start from a stop state with power present
    assign cab_ready     = target.status.stopped && target.power;
    assign activate_next = target.valid && cab_ready;
    assign going_up      = (target.floor > target.status.floor);

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dispatch <= '0;
        end else begin
            dispatch.floor_selector <= target.floor;
            dispatch.activate       <= activate_next;

            // Direction is only refreshed when a trip is being launched
            if (activate_next) begin
                dispatch.direction_up <= going_up;
            end

            dispatch.door_open_allowed  <= target.door_open  && cab_ready;
            dispatch.door_close_allowed <= target.door_close && cab_ready;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Never ask the motion machine to travel to where it already is
    property activate_moves_away;
        @(posedge clock) disable iff (!reset_n)
            dispatch.activate |-> dispatch.floor_selector != $past(target.status.floor);
    endproperty

    activate_check : assert property (activate_moves_away)
        else $error("activate raised with selector equal to cab floor");

endmodule

/* source/elevator_settings.svh */
// Sizing and state-code constants for the elevator floor-request controller.
// Include this header in any file that needs floor counts or state widths.

`ifndef ELEVATOR_SETTINGS_SVH
`define ELEVATOR_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Building size
////////////////////////////////////////////////////////////////////////////

// Floors served, indexed 0 to NUM_FLOORS-1
`define NUM_FLOORS 11

// Bits in one floor index
`define FLOOR_WIDTH 4

////////////////////////////////////////////////////////////////////////////
// Motion machine state codes
////////////////////////////////////////////////////////////////////////////

`define STATE_WIDTH 6

// Codes 0 up to this value mean stopped at the floor with that index
`define LAST_STOP_STATE 6'h0A

`endif

/* source/floor_logic_top.sv */
// Top level of the floor-request controller.
// Chains the request latch, scheduler and dispatch stages; an input sample
// reaches the dispatch outputs three rising edges later.

`timescale 1ns/1ps
`include "elevator_settings.svh"

module floor_logic_top (
    input  logic                    clock,
    input  logic                    reset_n,
    input  floor_pkg::button_req_t  buttons,
    input  logic                    power_switch,
    input  logic                    emergency_button,
    input  floor_pkg::floor_t       current_floor,
    input  logic [`STATE_WIDTH-1:0] elevator_state,
    input  logic                    elevator_direction,
    output floor_pkg::floor_mask_t  call_lights,
    output floor_pkg::floor_mask_t  panel_lights,
    output floor_pkg::dispatch_t    dispatch
);

    // Stage records
    floor_pkg::pending_t pending;
    floor_pkg::target_t  target;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////////////////////////////

    request_latch u_request_latch (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .power_switch       (power_switch),
        .emergency_button   (emergency_button),
        .current_floor      (current_floor),
        .elevator_state     (elevator_state),
        .elevator_direction (elevator_direction),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .pending            (pending)
    );

    floor_scheduler u_floor_scheduler (
        .clock   (clock),
        .reset_n (reset_n),
        .pending (pending),
        .target  (target)
    );

    dispatch_control u_dispatch_control (
        .clock    (clock),
        .reset_n  (reset_n),
        .target   (target),
        .dispatch (dispatch)
    );

endmodule

/* source/floor_pkg.sv */
// Shared types for the floor-request pipeline.
// Modules refer to these by scoped name, for example floor_pkg::pending_t.

`include "elevator_settings.svh"

package floor_pkg;

    // Floor index, 0 is the lowest floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////////////////////
    // Inputs and stage records
    ////////////////////////////////////////////////////////////////////////////

    // Raw button levels from the hall and the cab
    typedef struct packed {
        floor_mask_t call;
        floor_mask_t panel;
        logic        door_open;
        logic        door_close;
    } button_req_t;

    // Where the cab is and what it is doing
    typedef struct packed {
        floor_t floor;
        logic   stopped;
        logic   direction_up;
    } cab_status_t;

    // Stage 1 to stage 2
    typedef struct packed {
        floor_mask_t requests;
        cab_status_t status;
        logic        door_open;
        logic        door_close;
        logic        power;
    } pending_t;

    // Stage 2 to stage 3
    typedef struct packed {
        floor_t      floor;
        logic        valid;
        cab_status_t status;
        logic        door_open;
        logic        door_close;
        logic        power;
    } target_t;

    // Commands to the motion machine
    typedef struct packed {
        floor_t floor_selector;
        logic   activate;
        logic   direction_up;
        logic   door_open_allowed;
        logic   door_close_allowed;
    } dispatch_t;

endpackage

/* source/floor_scheduler.sv */
// Stage 2 of the floor-request pipeline.
// Picks the next target floor from the pending mask with a direction-aware
// nearest search and registers it together with the cab status.

`timescale 1ns/1ps
`include "elevator_settings.svh"

module floor_scheduler (
    input  logic                clock,
    input  logic                reset_n,
    input  floor_pkg::pending_t pending,
    output floor_pkg::target_t  target
);

    floor_pkg::floor_t cur_floor;
    logic              above_found;
    logic              below_found;
    floor_pkg::floor_t above_floor;
    floor_pkg::floor_t below_floor;
    logic              next_valid;
    floor_pkg::floor_t next_floor;

    assign cur_floor = pending.status.floor;

    ////////////////////////////////////////////////////////////////////////////
    // Nearest request on each side of the cab
    ////////////////////////////////////////////////////////////////////////////

    // Scanning from the top leaves the lowest hit above the cab
    always_comb begin
        above_found = 1'b0;
        above_floor = cur_floor;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (pending.requests[i] && (i > cur_floor)) begin
                above_found = 1'b1;
                above_floor = floor_pkg::floor_t'(i);
            end
        end
    end

    // Scanning from the bottom leaves the highest hit below the cab
    always_comb begin
        below_found = 1'b0;
        below_floor = cur_floor;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (pending.requests[i] && (i < cur_floor)) begin
                below_found = 1'b1;
                below_floor = floor_pkg::floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Direction preference
    ////////////////////////////////////////////////////////////////////////////

    // Keep going the current way if anything is there, else turn around
    always_comb begin
        next_valid = above_found || below_found;
        next_floor = cur_floor;
        if (pending.status.direction_up) begin
            if (above_found) begin
                next_floor = above_floor;
            end else if (below_found) begin
                next_floor = below_floor;
            end
        end else begin
            if (below_found) begin
                next_floor = below_floor;
            end else if (above_found) begin
                next_floor = above_floor;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Target register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target <= '0;
        end else begin
            target.floor      <= next_floor;
            target.valid      <= next_valid;
            target.status     <= pending.status;
            target.door_open  <= pending.door_open;
            target.door_close <= pending.door_close;
            target.power      <= pending.power;
        end
    end

    // A valid target is a real floor and never the one the cab is at
    property valid_target_elsewhere;
        @(posedge clock) disable iff (!reset_n)
            target.valid |-> (target.floor < `NUM_FLOORS)
                && (target.floor != target.status.floor);
    endproperty

    valid_target_check : assert property (valid_target_elsewhere)
        else $error("valid target out of range or equal to cab floor");

endmodule

/* source/request_latch.sv */
// Stage 1 of the floor-request pipeline.
// Latches hall and cab buttons into the light masks, clears served floors,
// and registers the pending mask with an aligned copy of the cab status.

`timescale 1ns/1ps
`include "elevator_settings.svh"

module request_latch (
    input  logic                    clock,
    input  logic                    reset_n,
    input  floor_pkg::button_req_t  buttons,
    input  logic                    power_switch,
    input  logic                    emergency_button,
    input  floor_pkg::floor_t       current_floor,
    input  logic [`STATE_WIDTH-1:0] elevator_state,
    input  logic                    elevator_direction,
    output floor_pkg::floor_mask_t  call_lights,
    output floor_pkg::floor_mask_t  panel_lights,
    output floor_pkg::pending_t     pending
);

    logic                   stopped;
    logic                   clear_all;
    floor_pkg::floor_mask_t here_mask;
    floor_pkg::floor_mask_t call_next;
    floor_pkg::floor_mask_t panel_next;
    floor_pkg::cab_status_t status;

    ////////////////////////////////////////////////////////////////////////////
    // Cab status decode
    ////////////////////////////////////////////////////////////////////////////

    // Stop states occupy the low codes, one per floor
    assign stopped   = (elevator_state <= `LAST_STOP_STATE);
    assign clear_all = !power_switch || emergency_button;

    // One-hot of the current floor, empty if the index is out of range
    assign here_mask = floor_pkg::floor_mask_t'(1) << current_floor;

    assign status = '{
        floor:        current_floor,
        stopped:      stopped,
        direction_up: elevator_direction
    };

    ////////////////////////////////////////////////////////////////////////////
    // Light update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (clear_all) begin
            call_next  = '0;
            panel_next = '0;
        end else begin
            // A press at the floor the cab is on is dropped
            call_next  = call_lights  | (buttons.call  & ~here_mask);
            panel_next = panel_lights | (buttons.panel & ~here_mask);

            // Stopping at a floor serves both of its requests
            if (stopped) begin
                call_next  = call_next  & ~here_mask;
                panel_next = panel_next & ~here_mask;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else begin
            call_lights  <= call_next;
            panel_lights <= panel_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending record to the scheduler
    ////////////////////////////////////////////////////////////////////////////

    // Mask and status leave on the same edge so stage 2 sees one sample
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending <= '0;
        end else begin
            pending.requests   <= call_next | panel_next;
            pending.status     <= status;
            pending.door_open  <= buttons.door_open;
            pending.door_close <= buttons.door_close;
            pending.power      <= power_switch;
        end
    end

    // Floor served on the last edge must come out unlit
    property served_floor_dark;
        @(posedge clock) disable iff (!reset_n)
            $past(stopped) |-> ((call_lights | panel_lights) & $past(here_mask)) == '0;
    endproperty

    served_floor_dark_check : assert property (served_floor_dark)
        else $error("light set for the floor the cab was stopped at");

endmodule

/* tests/floor_logic_checker.sv */
// Output checker for the floor-request controller testbench.
// Compares the DUT outputs with the expected row on every edge where the
// testbench raises check_en, and keeps running check and error counts.

`timescale 1ns/1ps

module floor_logic_checker (
    input  logic                   clock,
    input  logic                   check_en,
    input  int                     row_index,
    input  floor_pkg::floor_mask_t call_lights,
    input  floor_pkg::floor_mask_t panel_lights,
    input  floor_pkg::dispatch_t   dispatch,
    input  floor_pkg::floor_mask_t exp_call,
    input  floor_pkg::floor_mask_t exp_panel,
    input  floor_pkg::dispatch_t   exp_dispatch,
    output int                     error_count,
    output int                     check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // One field against its expected value
    task compare_field(
        input string       name,
        input logic [15:0] got,
        input logic [15:0] want
    );
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %s (row %0d): got 0x%0h, expected 0x%0h",
                     name, row_index, got, want);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparison on the last edge of each row
    ////////////////////////////////////////////////////////////////////////////

    // Outputs read here were settled by the previous edge
    always @(posedge clock) begin
        if (check_en) begin
            compare_field("call_lights", call_lights, exp_call);
            compare_field("panel_lights", panel_lights, exp_panel);
            compare_field("dispatch.floor_selector", dispatch.floor_selector,
                          exp_dispatch.floor_selector);
            compare_field("dispatch.activate", dispatch.activate,
                          exp_dispatch.activate);
            compare_field("dispatch.direction_up", dispatch.direction_up,
                          exp_dispatch.direction_up);
            compare_field("dispatch.door_open_allowed", dispatch.door_open_allowed,
                          exp_dispatch.door_open_allowed);
            compare_field("dispatch.door_close_allowed", dispatch.door_close_allowed,
                          exp_dispatch.door_close_allowed);
        end
    end

endmodule

/* tests/floor_logic_tb.sv */
// Testbench for the floor-request controller.
// Applies a table of input rows, each held for four cycles, and lets the
// checker compare lights and dispatch outputs on the last edge of each row.

`timescale 1ns/1ps
`include "elevator_settings.svh"

module floor_logic_tb;

    // One table row: inputs, then the expected outputs once the pipeline settles
    typedef struct packed {
        floor_pkg::floor_mask_t  call;
        floor_pkg::floor_mask_t  panel;
        logic [1:0]              doors;
        logic                    power;
        logic                    emergency;
        floor_pkg::floor_t       floor;
        logic [`STATE_WIDTH-1:0] state;
        logic                    direction_up;
        floor_pkg::floor_mask_t  exp_call;
        floor_pkg::floor_mask_t  exp_panel;
        floor_pkg::dispatch_t    exp_dispatch;
    } row_t;

    logic                    clock;
    logic                    reset_n;
    floor_pkg::button_req_t  buttons;
    logic                    power_switch;
    logic                    emergency_button;
    floor_pkg::floor_t       current_floor;
    logic [`STATE_WIDTH-1:0] elevator_state;
    logic                    elevator_direction;
    floor_pkg::floor_mask_t  call_lights;
    floor_pkg::floor_mask_t  panel_lights;
    floor_pkg::dispatch_t    dispatch;

    row_t        rows[$];
    row_t        current_row;
    int          row_index;
    logic        check_en;
    int          error_count;
    int          check_count;
    int          timeout_limit;
    int          cycle_count = 0;

    floor_logic_top UUT (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .power_switch       (power_switch),
        .emergency_button   (emergency_button),
        .current_floor      (current_floor),
        .elevator_state     (elevator_state),
        .elevator_direction (elevator_direction),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .dispatch           (dispatch)
    );

    floor_logic_checker output_check (
        .clock        (clock),
        .check_en     (check_en),
        .row_index    (row_index),
        .call_lights  (call_lights),
        .panel_lights (panel_lights),
        .dispatch     (dispatch),
        .exp_call     (current_row.exp_call),
        .exp_panel    (current_row.exp_panel),
        .exp_dispatch (current_row.exp_dispatch),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic add_row(
        input floor_pkg::floor_mask_t  call,
        input floor_pkg::floor_mask_t  panel,
        input logic [1:0]              doors,
        input logic                    power,
        input logic                    emergency,
        input floor_pkg::floor_t       floor,
        input logic [`STATE_WIDTH-1:0] state,
        input logic                    direction_up,
        input floor_pkg::floor_mask_t  exp_call,
        input floor_pkg::floor_mask_t  exp_panel,
        input floor_pkg::floor_t       exp_sel,
        input logic                    exp_activate,
        input logic                    exp_up,
        input logic [1:0]              exp_doors
    );
        row_t r;
        r.call                            = call;
        r.panel                           = panel;
        r.doors                           = doors;
        r.power                           = power;
        r.emergency                       = emergency;
        r.floor                           = floor;
        r.state                           = state;
        r.direction_up                    = direction_up;
        r.exp_call                        = exp_call;
        r.exp_panel                       = exp_panel;
        r.exp_dispatch.floor_selector     = exp_sel;
        r.exp_dispatch.activate           = exp_activate;
        r.exp_dispatch.direction_up       = exp_up;
        r.exp_dispatch.door_open_allowed  = exp_doors[1];
        r.exp_dispatch.door_close_allowed = exp_doors[0];
        rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    // Columns: call, panel, {open,close}, power, emergency, floor, state, up,
    // then expected call, panel, selector, activate, up, {open,close}
    task automatic build_table();
        // Idle at floor 0, then presses with the floor 0 call dropped
        add_row(11'h000, 11'h000, 2'b00, 1, 0, 4'd0, 6'h00, 1, 11'h000, 11'h000, 4'd0, 0, 0, 2'b00);
        add_row(11'h021, 11'h008, 2'b00, 1, 0, 4'd0, 6'h00, 1, 11'h020, 11'h008, 4'd3, 1, 1, 2'b00);
        add_row(11'h000, 11'h000, 2'b10, 1, 0, 4'd0, 6'h00, 1, 11'h020, 11'h008, 4'd3, 1, 1, 2'b10);
        // Travelling past 1 drops presses there, then stop at 3 clears its panel light
        add_row(11'h002, 11'h002, 2'b00, 1, 0, 4'd1, 6'h20, 1, 11'h020, 11'h008, 4'd3, 0, 1, 2'b00);
        add_row(11'h000, 11'h000, 2'b01, 1, 0, 4'd3, 6'h03, 1, 11'h020, 11'h000, 4'd5, 1, 1, 2'b01);
        // Requests on both sides, up picks 5 and down picks 1
        add_row(11'h100, 11'h002, 2'b00, 1, 0, 4'd3, 6'h03, 1, 11'h120, 11'h002, 4'd5, 1, 1, 2'b00);
        add_row(11'h000, 11'h000, 2'b00, 1, 0, 4'd3, 6'h03, 0, 11'h120, 11'h002, 4'd1, 1, 0, 2'b00);
        add_row(11'h000, 11'h000, 2'b00, 1, 0, 4'd2, 6'h21, 0, 11'h120, 11'h002, 4'd1, 0, 0, 2'b00);
        // Down with nothing below turns around to 5
        add_row(11'h000, 11'h000, 2'b00, 1, 0, 4'd1, 6'h01, 0, 11'h120, 11'h000, 4'd5, 1, 1, 2'b00);
        // Stopping at 5 serves its hall call and leaves 8
        add_row(11'h000, 11'h000, 2'b00, 1, 0, 4'd5, 6'h05, 1, 11'h100, 11'h000, 4'd8, 1, 1, 2'b00);
        // Up with nothing above goes to 8, then a call at 10 wins
        add_row(11'h000, 11'h200, 2'b00, 1, 0, 4'd9, 6'h09, 1, 11'h100, 11'h000, 4'd8, 1, 0, 2'b00);
        add_row(11'h400, 11'h000, 2'b00, 1, 0, 4'd9, 6'h09, 1, 11'h500, 11'h000, 4'd10, 1, 1, 2'b00);
        // Emergency clears everything
        add_row(11'h000, 11'h000, 2'b00, 1, 1, 4'd9, 6'h09, 1, 11'h000, 11'h000, 4'd9, 0, 1, 2'b00);
        add_row(11'h004, 11'h040, 2'b00, 1, 0, 4'd9, 6'h09, 0, 11'h004, 11'h040, 4'd6, 1, 0, 2'b00);
        // Power off, then back on with a door request
        add_row(11'h000, 11'h000, 2'b00, 0, 0, 4'd9, 6'h09, 0, 11'h000, 11'h000, 4'd9, 0, 0, 2'b00);
        add_row(11'h000, 11'h010, 2'b10, 1, 0, 4'd9, 6'h09, 0, 11'h000, 11'h010, 4'd4, 1, 0, 2'b10);
        add_row(11'h000, 11'h000, 2'b00, 1, 0, 4'd7, 6'h22, 0, 11'h000, 11'h010, 4'd4, 0, 0, 2'b00);
    endtask

    task automatic apply_row(input row_t r);
        logic stopped;
        stopped            = (r.state <= `LAST_STOP_STATE);
        buttons.call       = r.call;
        buttons.panel      = r.panel;
        buttons.door_open  = r.doors[1];
        buttons.door_close = r.doors[0];
        power_switch       = r.power;
        emergency_button   = r.emergency;
        current_floor      = r.floor;
        elevator_state     = r.state;
        elevator_direction = r.direction_up;
        // Floor buttons have no effect while the lights are held clear
        if (!r.power || r.emergency) begin
            buttons.call  = floor_pkg::floor_mask_t'($urandom);
            buttons.panel = floor_pkg::floor_mask_t'($urandom);
        end
        // Door buttons are ignored unless stopped with power on
        if (!r.power || !stopped) begin
            buttons.door_open  = $urandom_range(1, 0);
            buttons.door_close = $urandom_range(1, 0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles",
                     timeout_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf1f2_89a2));
        reset_n            = 1'b0;
        buttons            = '0;
        power_switch       = 1'b0;
        emergency_button   = 1'b0;
        current_floor      = '0;
        elevator_state     = '0;
        elevator_direction = 1'b0;
        check_en           = 1'b0;
        row_index          = 0;
        current_row        = '0;
        build_table();
        timeout_limit = 8 + rows.size() * 4 + 20;

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        // Hold each row four cycles; the pipeline needs three edges
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clock);
            check_en    = 1'b0;
            row_index   = i;
            current_row = rows[i];
            apply_row(rows[i]);
            repeat (3) @(negedge clock);
            check_en = 1'b1;
        end
        @(negedge clock);
        check_en = 1'b0;

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (check_count != rows.size() * 7) begin
            $display("Not every table row was compared by the checker");
        end
        if (error_count == 0 && check_count == rows.size() * 7) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
